// ==== Makefile ====
# Verilator build for the nes debugger memory access core

VERILATOR ?= verilator
TOP       ?= tb_nes_debugger
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the result is decided by the pass line in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/dbg_pkg.sv ====
/*
 * nes debugger shared definitions
 * widths, debugger register map and the pool memory request bus
 */
package dbg_pkg;

  // default sizes, the top level overrides and passes them down
  localparam int NUM_POOLS = 4;
  localparam int MEM_AW = 12;

  // pool memory address as seen by nes and debugger
  typedef logic [15:0] addr_t;

  // memory and register data
  typedef logic [7:0] data_t;

  // index of the selected memory pool
  typedef logic [1:0] pool_t;

  // wishbone word address, bit 16 set selects register space
  typedef logic [16:0] wb_adr_t;

  // register offsets within register space
  // bit 0 is nes_run, releases nes reset when set
  localparam addr_t REG_CTRL = 16'h0000;
  // bits 1:0 select the pool behind the memory window
  localparam addr_t REG_POOL = 16'h0001;

  // one memory access request, same shape on nes and debugger side
  typedef struct packed {
    logic  en;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

endpackage

// ==== hdl/dbg_wb_slave.sv ====
/*
 * wishbone classic slave for the debugger
 * holds run control and pool select, forwards memory window accesses
 */
module dbg_wb_slave #(
  parameter int NUM_POOLS = 4
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_wb_cyc,
  input  logic                 i_wb_stb,
  input  logic                 i_wb_we,
  input  dbg_pkg::wb_adr_t     i_wb_adr,
  input  dbg_pkg::data_t       i_wb_dat,
  input  logic                 i_done,
  input  dbg_pkg::data_t       i_rdata,
  output dbg_pkg::data_t       o_wb_dat,
  output logic                 o_wb_ack,
  output dbg_pkg::mem_req_t    o_dbg_req,
  output logic [NUM_POOLS-1:0] o_pool_en,
  output dbg_pkg::pool_t       o_pool_sel,
  output logic                 o_nes_rst
);

  typedef enum logic [1:0] {
    IDLE,
    MEM_WAIT,
    ACK
  } state_t;

  state_t         state;
  logic           nes_run;
  dbg_pkg::pool_t pool_sel;
  dbg_pkg::data_t reg_rdata;
  logic           req_en;
  logic           req_we;
  dbg_pkg::addr_t req_addr;
  dbg_pkg::data_t req_wdata;
  logic           wb_req;
  logic           reg_space;
  dbg_pkg::addr_t offset;

  assign wb_req = i_wb_cyc & i_wb_stb;
  assign reg_space = i_wb_adr[16];
  assign offset = i_wb_adr[15:0];

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      state <= IDLE;
      nes_run <= 1'b0;
      pool_sel <= '0;
      req_en <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (wb_req && reg_space)
          begin
            state <= ACK;
            if (i_wb_we)
            begin
              case (offset)
                dbg_pkg::REG_CTRL: nes_run <= i_wb_dat[0];
                dbg_pkg::REG_POOL: pool_sel <= i_wb_dat[1:0];
                default: ;
              endcase
            end
          end
          else if (wb_req)
          begin
            req_en <= 1'b1;
            state <= MEM_WAIT;
          end
        end
        // request held until the return stage reports done
        MEM_WAIT:
        begin
          if (i_done)
          begin
            req_en <= 1'b0;
            state <= IDLE;
          end
        end
        ACK: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // request payload and register read data
  always_ff @(posedge i_clk)
  begin
    if (state == IDLE && wb_req)
    begin
      req_we <= i_wb_we;
      req_addr <= offset;
      req_wdata <= i_wb_dat;
      case (offset)
        dbg_pkg::REG_CTRL: reg_rdata <= dbg_pkg::data_t'(nes_run);
        dbg_pkg::REG_POOL: reg_rdata <= dbg_pkg::data_t'(pool_sel);
        default: reg_rdata <= '0;
      endcase
    end
  end

  always_comb
  begin
    o_dbg_req.en = req_en;
    o_dbg_req.we = req_we;
    o_dbg_req.addr = req_addr;
    o_dbg_req.wdata = req_wdata;
    for (int i = 0; i < NUM_POOLS; i++)
    begin
      o_pool_en[i] = req_en & (pool_sel == dbg_pkg::pool_t'(i));
    end
  end

  // memory acks together with the done pulse, registers one cycle after stb
  always_comb
  begin
    o_wb_ack = (state == ACK) | ((state == MEM_WAIT) & i_done);
    o_wb_dat = (state == MEM_WAIT) ? i_rdata : reg_rdata;
  end

  assign o_pool_sel = pool_sel;
  assign o_nes_rst = ~nes_run;

  a_ack_in_cycle: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_wb_ack |-> (i_wb_cyc && i_wb_stb)
  );

  a_pool_en_onehot: assert property (
    @(posedge i_clk) disable iff (i_rst)
    $onehot0(o_pool_en)
  );

endmodule

// ==== hdl/mem_block.sv ====
/*
 * pool memory block
 * single port, synchronous write, registered read
 */
module mem_block #(
  parameter int MEM_AW = 12
) (
  input  logic           i_clk,
  input  logic           i_en,
  input  logic           i_we,
  input  dbg_pkg::addr_t i_addr,
  input  dbg_pkg::data_t i_wdata,
  output dbg_pkg::data_t o_rdata
);

  dbg_pkg::data_t    mem [2**MEM_AW];
  logic [MEM_AW-1:0] idx;

  // upper address bits alias onto the stored range
  assign idx = i_addr[MEM_AW-1:0];

  // read data only changes on a read access
  always_ff @(posedge i_clk)
  begin
    if (i_en)
    begin
      if (i_we)
      begin
        mem[idx] <= i_wdata;
      end
      else
      begin
        o_rdata <= mem[idx];
      end
    end
  end

endmodule

// ==== hdl/mem_pool_mcu.sv ====
/*
 * memory control unit for one pool
 * nes side always wins, debugger side waits for a free cycle
 */
module mem_pool_mcu #(
  parameter int MEM_AW = 12
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_nes_phi2,
  input  dbg_pkg::mem_req_t i_nes_req,
  input  dbg_pkg::mem_req_t i_dbg_req,
  output dbg_pkg::data_t    o_nes_rdata,
  output logic              o_dbg_grant,
  output dbg_pkg::data_t    o_dbg_rdata
);

  logic              nes_act;
  logic              dbg_issued;
  logic              nes_rd_q;
  logic              dbg_rd_q;
  dbg_pkg::mem_req_t mem_req;
  dbg_pkg::data_t    mem_rdata;
  dbg_pkg::data_t    nes_hold;
  dbg_pkg::data_t    dbg_hold;

  // cpu memory access happens during phi2 high
  assign nes_act = i_nes_req.en & i_nes_phi2;

  // one grant per debugger request, en drops before the next one
  assign o_dbg_grant = i_dbg_req.en & ~dbg_issued & ~nes_act;

  // memory port mux
  always_comb
  begin
    mem_req = i_dbg_req;
    mem_req.en = o_dbg_grant;
    if (nes_act)
    begin
      mem_req = i_nes_req;
    end
  end

  mem_block #(
    .MEM_AW (MEM_AW)
  ) u_mem (
    .i_clk   (i_clk),
    .i_en    (mem_req.en),
    .i_we    (mem_req.we),
    .i_addr  (mem_req.addr),
    .i_wdata (mem_req.wdata),
    .o_rdata (mem_rdata)
  );

  // owner of the previous cycle's read
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      dbg_issued <= 1'b0;
      nes_rd_q <= 1'b0;
      dbg_rd_q <= 1'b0;
    end
    else
    begin
      if (!i_dbg_req.en)
      begin
        dbg_issued <= 1'b0;
      end
      else if (o_dbg_grant)
      begin
        dbg_issued <= 1'b1;
      end
      nes_rd_q <= nes_act & ~i_nes_req.we;
      dbg_rd_q <= o_dbg_grant & ~i_dbg_req.we;
    end
  end

  // keep each side's last read once the other side takes the port
  always_ff @(posedge i_clk)
  begin
    if (nes_rd_q)
    begin
      nes_hold <= mem_rdata;
    end
    if (dbg_rd_q)
    begin
      dbg_hold <= mem_rdata;
    end
  end

  assign o_nes_rdata = nes_rd_q ? mem_rdata : nes_hold;
  assign o_dbg_rdata = dbg_rd_q ? mem_rdata : dbg_hold;

  // nes is never stalled by the debugger
  a_no_grant_on_nes: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (i_nes_req.en && i_nes_phi2) |-> !o_dbg_grant
  );

endmodule

// ==== hdl/nes_debugger_top.sv ====
/*
 * nes debugger memory access core
 * wishbone slave, one memory control unit per pool and the read return
 */
module nes_debugger_top #(
  parameter int NUM_POOLS = dbg_pkg::NUM_POOLS,
  parameter int MEM_AW = dbg_pkg::MEM_AW
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_nes_phi2,
  input  logic              i_wb_cyc,
  input  logic              i_wb_stb,
  input  logic              i_wb_we,
  input  dbg_pkg::wb_adr_t  i_wb_adr,
  input  dbg_pkg::data_t    i_wb_dat,
  output dbg_pkg::data_t    o_wb_dat,
  output logic              o_wb_ack,
  input  dbg_pkg::mem_req_t i_nes_req [NUM_POOLS],
  output dbg_pkg::data_t    o_nes_rdata [NUM_POOLS],
  output logic              o_nes_rst
);

  dbg_pkg::mem_req_t    dbg_req;
  logic [NUM_POOLS-1:0] pool_en;
  logic [NUM_POOLS-1:0] grant;
  dbg_pkg::data_t       pool_rdata [NUM_POOLS];
  logic                 done;
  dbg_pkg::data_t       ret_rdata;

  dbg_wb_slave #(
    .NUM_POOLS (NUM_POOLS)
  ) u_slave (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_wb_cyc   (i_wb_cyc),
    .i_wb_stb   (i_wb_stb),
    .i_wb_we    (i_wb_we),
    .i_wb_adr   (i_wb_adr),
    .i_wb_dat   (i_wb_dat),
    .i_done     (done),
    .i_rdata    (ret_rdata),
    .o_wb_dat   (o_wb_dat),
    .o_wb_ack   (o_wb_ack),
    .o_dbg_req  (dbg_req),
    .o_pool_en  (pool_en),
    .o_pool_sel (),
    .o_nes_rst  (o_nes_rst)
  );

  // prg, ram, pattern table, nametable by default
  for (genvar i = 0; i < NUM_POOLS; i++)
  begin : g_pool
    dbg_pkg::mem_req_t unit_req;

    // only the selected pool sees the debugger request
    always_comb
    begin
      unit_req = dbg_req;
      unit_req.en = dbg_req.en & pool_en[i];
    end

    mem_pool_mcu #(
      .MEM_AW (MEM_AW)
    ) u_mcu (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_nes_phi2  (i_nes_phi2),
      .i_nes_req   (i_nes_req[i]),
      .i_dbg_req   (unit_req),
      .o_nes_rdata (o_nes_rdata[i]),
      .o_dbg_grant (grant[i]),
      .o_dbg_rdata (pool_rdata[i])
    );
  end

  pool_read_return #(
    .NUM_POOLS (NUM_POOLS)
  ) u_return (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_grant      (grant),
    .i_pool_rdata (pool_rdata),
    .o_done       (done),
    .o_rdata      (ret_rdata)
  );

endmodule

// ==== hdl/pool_read_return.sv ====
/*
 * debugger read return
 * merges per-pool grants and read data into one registered done pulse
 */
module pool_read_return #(
  parameter int NUM_POOLS = 4
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic [NUM_POOLS-1:0] i_grant,
  input  dbg_pkg::data_t       i_pool_rdata [NUM_POOLS],
  output logic                 o_done,
  output dbg_pkg::data_t       o_rdata
);

  logic [NUM_POOLS-1:0] grant_q;
  dbg_pkg::data_t       sel_rdata;

  // grant delayed by the memory read latency
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      grant_q <= '0;
      o_done <= 1'b0;
    end
    else
    begin
      grant_q <= i_grant;
      o_done <= |grant_q;
    end
  end

  // data of the pool that was granted
  always_comb
  begin
    sel_rdata = '0;
    for (int i = 0; i < NUM_POOLS; i++)
    begin
      if (grant_q[i])
      begin
        sel_rdata = i_pool_rdata[i];
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    o_rdata <= sel_rdata;
  end

  // only one debugger request in flight over all pools
  a_grant_onehot: assert property (
    @(posedge i_clk) disable iff (i_rst)
    $onehot0(grant_q)
  );

endmodule

// ==== list.f ====
+incdir+include
hdl/dbg_pkg.sv
hdl/mem_block.sv
hdl/mem_pool_mcu.sv
hdl/pool_read_return.sv
hdl/dbg_wb_slave.sv
hdl/nes_debugger_top.sv
tests/tb_nes_debugger.sv

// ==== include/tb_wb_host.svh ====
/*
 * testbench host tasks
 * wishbone classic single reads and writes, nes port driving
 */
`ifndef TB_WB_HOST_SVH
`define TB_WB_HOST_SVH

// one wishbone classic cycle, returns one drive delay after the ack edge
task automatic wb_access(
  input logic             we,
  input dbg_pkg::wb_adr_t adr,
  input dbg_pkg::data_t   dat
);
  int n;
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  wb_we = we;
  wb_adr = adr;
  wb_dat = dat;
  n = 0;
  @(negedge clk);
  // n counts rising edges between stb and ack
  while (!wb_ack)
  begin
    @(negedge clk);
    n++;
  end
  // memory window goes through request, grant, read and return
  if (!adr[16])
  begin
    assert (n >= 3)
    else report_failure($sformatf("** Error at %0d ns: o_wb_ack latency expected >= 3 got %0d",
                                  $time, n));
  end
  else
  begin
    // register space answers in the cycle after stb
    assert (n == 1)
    else report_failure($sformatf("** Error at %0d ns: o_wb_ack latency expected 1 got %0d",
                                  $time, n));
  end
  @(posedge clk);
  #DRIVE_DLY;
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  wb_we = 1'b0;
endtask

task automatic wb_write(input dbg_pkg::wb_adr_t adr, input dbg_pkg::data_t dat);
  wb_access(1'b1, adr, dat);
endtask

// read data is checked by the compare process
task automatic wb_read(input dbg_pkg::wb_adr_t adr);
  wb_access(1'b0, adr, '0);
endtask

task automatic nes_set(
  input int             p,
  input logic           we,
  input dbg_pkg::addr_t a,
  input dbg_pkg::data_t d
);
  nes_req[p].en = 1'b1;
  nes_req[p].we = we;
  nes_req[p].addr = a;
  nes_req[p].wdata = d;
endtask

task automatic nes_clear();
  for (int p = 0; p < NUM_POOLS; p++)
  begin
    nes_req[p] = '0;
  end
endtask

// requests set before this take effect at the next rising edge
task automatic nes_step();
  @(posedge clk);
  #DRIVE_DLY;
endtask

`endif

// ==== tests/tb_nes_debugger.sv ====
/*
 * testbench for the nes debugger memory access core
 * shadow model per pool, wishbone and nes stimulus, compare process
 */
module tb_nes_debugger;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_POOLS = 4;
  localparam int MEM_AW = 12;
  localparam int CLK_HALF = 4;
  localparam int DRIVE_DLY = 1;
  localparam int SEED = 48;
  localparam int N_WR = 8;
  localparam int N_NES = 8;
  localparam int N_MIX = 6;
  // wishbone cycles and nes steps over all tests
  localparam int N_TXN = 16 + 2 * NUM_POOLS * (N_WR + 1) + 3 * N_NES + N_WR + 2 * N_MIX + 16;
  localparam int WDOG_CYCLES = 200 * N_TXN;

  logic              clk;
  logic              rst;
  logic              nes_phi2;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  dbg_pkg::wb_adr_t  wb_adr;
  dbg_pkg::data_t    wb_dat;
  dbg_pkg::data_t    wb_rdat;
  logic              wb_ack;
  dbg_pkg::mem_req_t nes_req [NUM_POOLS];
  dbg_pkg::data_t    nes_rdata [NUM_POOLS];
  logic              nes_rst;

  // reference state
  dbg_pkg::data_t       shadow [NUM_POOLS][2**MEM_AW];
  logic                 ctrl_m;
  dbg_pkg::pool_t       pool_m;
  logic [NUM_POOLS-1:0] nes_pend;
  dbg_pkg::data_t       nes_exp [NUM_POOLS];
  dbg_pkg::data_t       wb_exp;

  // stimulus state
  dbg_pkg::addr_t dbg_addr [NUM_POOLS][N_WR];
  dbg_pkg::addr_t addr_v;
  logic           mix_done;

  nes_debugger_top #(
    .NUM_POOLS (NUM_POOLS),
    .MEM_AW    (MEM_AW)
  ) i_dut (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_nes_phi2  (nes_phi2),
    .i_wb_cyc    (wb_cyc),
    .i_wb_stb    (wb_stb),
    .i_wb_we     (wb_we),
    .i_wb_adr    (wb_adr),
    .i_wb_dat    (wb_dat),
    .o_wb_dat    (wb_rdat),
    .o_wb_ack    (wb_ack),
    .i_nes_req   (nes_req),
    .o_nes_rdata (nes_rdata),
    .o_nes_rst   (nes_rst)
  );

  always #CLK_HALF clk = ~clk;

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  `include "tb_wb_host.svh"

  // stored byte for a pool, upper address bits alias
  function automatic dbg_pkg::data_t ref_read(input int p, input dbg_pkg::addr_t a);
    return shadow[p][a[MEM_AW-1:0]];
  endfunction

  function automatic dbg_pkg::data_t wb_expect(input dbg_pkg::wb_adr_t adr);
    dbg_pkg::data_t d;
    d = '0;
    if (!adr[16])
    begin
      d = ref_read(int'(pool_m), adr[15:0]);
    end
    else if (adr[15:0] == dbg_pkg::REG_CTRL)
    begin
      d = {7'b0, ctrl_m};
    end
    else if (adr[15:0] == dbg_pkg::REG_POOL)
    begin
      d = {6'b0, pool_m};
    end
    return d;
  endfunction

  // undefined register offsets change nothing
  task automatic apply_wb_write(input dbg_pkg::wb_adr_t adr, input dbg_pkg::data_t dat);
    if (!adr[16])
    begin
      shadow[pool_m][adr[MEM_AW-1:0]] = dat;
    end
    else if (adr[15:0] == dbg_pkg::REG_CTRL)
    begin
      ctrl_m = dat[0];
    end
    else if (adr[15:0] == dbg_pkg::REG_POOL)
    begin
      pool_m = dat[1:0];
    end
  endtask

  function automatic dbg_pkg::wb_adr_t reg_adr(input dbg_pkg::addr_t off);
    return {1'b1, off};
  endfunction

  function automatic dbg_pkg::wb_adr_t mem_adr(input dbg_pkg::addr_t a);
    return {1'b0, a};
  endfunction

  // debugger addresses sit in the upper half of the stored range
  function automatic dbg_pkg::addr_t upper_addr();
    dbg_pkg::addr_t a;
    a = dbg_pkg::addr_t'($urandom);
    a[MEM_AW-1] = 1'b1;
    return a;
  endfunction

  // random nes reads and writes on the low addresses of every pool
  task automatic nes_traffic();
    while (!mix_done)
    begin
      for (int p = 0; p < NUM_POOLS; p++)
      begin
        if ($urandom_range(3) != 0)
        begin
          nes_set(p, 1'($urandom_range(1)), dbg_pkg::addr_t'($urandom_range(N_NES - 1)),
                  dbg_pkg::data_t'($urandom));
        end
        else
        begin
          nes_req[p].en = 1'b0;
        end
      end
      nes_step();
    end
    nes_clear();
  endtask

  // nes accesses sampled at the edge, results checked half a cycle later
  always @(posedge clk)
  begin
    nes_pend = '0;
    if (!rst)
    begin
      for (int p = 0; p < NUM_POOLS; p++)
      begin
        if (nes_req[p].en && nes_phi2)
        begin
          if (nes_req[p].we)
          begin
            shadow[p][nes_req[p].addr[MEM_AW-1:0]] = nes_req[p].wdata;
          end
          else
          begin
            nes_pend[p] = 1'b1;
            nes_exp[p] = ref_read(p, nes_req[p].addr);
          end
        end
      end
    end
    @(negedge clk);
    for (int p = 0; p < NUM_POOLS; p++)
    begin
      if (nes_pend[p])
      begin
        assert (nes_rdata[p] === nes_exp[p])
        else report_failure($sformatf("** Error at %0d ns: o_nes_rdata[%0d] expected %h got %h",
                                      $time, p, nes_exp[p], nes_rdata[p]));
      end
    end
    // ack only ever answers an active bus cycle
    assert (rst || !wb_ack || (wb_cyc && wb_stb))
    else report_failure($sformatf("** Error at %0d ns: o_wb_ack expected 0 got %b",
                                  $time, wb_ack));
    if (!rst && wb_cyc && wb_stb && wb_ack)
    begin
      if (wb_we)
      begin
        apply_wb_write(wb_adr, wb_dat);
      end
      else
      begin
        wb_exp = wb_expect(wb_adr);
        assert (wb_rdat === wb_exp)
        else report_failure($sformatf("** Error at %0d ns: o_wb_dat expected %h got %h",
                                      $time, wb_exp, wb_rdat));
      end
    end
  end

  initial
  begin
    repeat (WDOG_CYCLES) @(posedge clk);
    report_failure($sformatf("watchdog expired after %0d cycles, a bus cycle never acknowledged",
                             WDOG_CYCLES));
  end

  initial
  begin
    void'($urandom(SEED));
    clk = 1'b0;
    rst = 1'b1;
    nes_phi2 = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat = '0;
    ctrl_m = 1'b0;
    pool_m = '0;
    mix_done = 1'b0;
    nes_clear();
    repeat (10) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    // run control and pool select
    assert (nes_rst === 1'b1)
    else report_failure($sformatf("** Error at %0d ns: o_nes_rst expected 1 got %b", $time, nes_rst));
    wb_read(reg_adr(dbg_pkg::REG_CTRL));
    wb_read(reg_adr(dbg_pkg::REG_POOL));
    wb_write(reg_adr(dbg_pkg::REG_CTRL), 8'h01);
    assert (nes_rst === 1'b0)
    else report_failure($sformatf("** Error at %0d ns: o_nes_rst expected 0 got %b", $time, nes_rst));
    wb_read(reg_adr(dbg_pkg::REG_CTRL));
    wb_write(reg_adr(dbg_pkg::REG_POOL), 8'h02);
    wb_read(reg_adr(dbg_pkg::REG_POOL));
    // data differs from both registers so a decoded write would show
    wb_write(reg_adr(16'h0007), 8'h5c);
    wb_read(reg_adr(16'h0007));
    wb_read(reg_adr(dbg_pkg::REG_CTRL));
    wb_read(reg_adr(dbg_pkg::REG_POOL));

    // debugger writes and reads per pool, then every pool again
    for (int p = 0; p < NUM_POOLS; p++)
    begin
      wb_write(reg_adr(dbg_pkg::REG_POOL), dbg_pkg::data_t'(p));
      for (int i = 0; i < N_WR; i++)
      begin
        // same addresses in every pool, so a crossed pool shows up
        if (p == 0)
        begin
          dbg_addr[p][i] = upper_addr();
        end
        else
        begin
          dbg_addr[p][i] = dbg_addr[0][i];
        end
        wb_write(mem_adr(dbg_addr[p][i]), dbg_pkg::data_t'($urandom));
      end
      for (int i = 0; i < N_WR; i++)
      begin
        wb_read(mem_adr(dbg_addr[p][i]));
      end
    end
    for (int p = 0; p < NUM_POOLS; p++)
    begin
      wb_write(reg_adr(dbg_pkg::REG_POOL), dbg_pkg::data_t'(p));
      for (int i = 0; i < N_WR; i++)
      begin
        wb_read(mem_adr(dbg_addr[p][i]));
      end
    end

    // nes writes and reads on all pools together
    for (int i = 0; i < N_NES; i++)
    begin
      for (int p = 0; p < NUM_POOLS; p++)
      begin
        nes_set(p, 1'b1, dbg_pkg::addr_t'(i), dbg_pkg::data_t'($urandom));
      end
      nes_step();
    end
    for (int i = 0; i < N_NES; i++)
    begin
      for (int p = 0; p < NUM_POOLS; p++)
      begin
        nes_set(p, 1'b0, dbg_pkg::addr_t'(i), '0);
      end
      nes_step();
    end
    // nes sees what the debugger wrote
    for (int i = 0; i < N_WR; i++)
    begin
      for (int p = 0; p < NUM_POOLS; p++)
      begin
        nes_set(p, 1'b0, dbg_addr[p][i], '0);
      end
      nes_step();
    end
    nes_clear();
    nes_step();

    // debugger accesses under nes traffic
    wb_write(reg_adr(dbg_pkg::REG_POOL), 8'h01);
    fork
      nes_traffic();
      begin
        for (int i = 0; i < N_MIX; i++)
        begin
          addr_v = upper_addr();
          wb_write(mem_adr(addr_v), dbg_pkg::data_t'($urandom));
          wb_read(mem_adr(addr_v));
        end
        mix_done = 1'b1;
      end
    join

    // phi2 low leaves memory untouched
    nes_phi2 = 1'b0;
    nes_set(0, 1'b1, 16'h0003, ~ref_read(0, 16'h0003));
    nes_step();
    nes_clear();
    nes_phi2 = 1'b1;
    nes_set(0, 1'b0, 16'h0003, '0);
    nes_step();
    nes_clear();
    nes_step();

    // upper address bits alias onto the stored range
    addr_v = dbg_pkg::addr_t'((1 << MEM_AW) | 5);
    wb_write(reg_adr(dbg_pkg::REG_POOL), 8'h02);
    wb_write(mem_adr(addr_v), dbg_pkg::data_t'($urandom));
    wb_read(mem_adr(16'h0005));
    nes_set(2, 1'b0, 16'h0005, '0);
    nes_set(3, 1'b1, 16'hf006, dbg_pkg::data_t'($urandom));
    nes_step();
    nes_clear();
    nes_step();
    wb_write(reg_adr(dbg_pkg::REG_POOL), 8'h03);
    wb_read(mem_adr(16'h0006));

    $display("NO ERRORS");
    $finish;
  end

endmodule
